/* rvCore_params.svh */
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`define RV_XLEN 32
`define RV_REG_AW 5

`endif

/* rvPkg.sv */
`include "rvCore_params.svh"

package rvPkg;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra
    } aluOpT;

    typedef enum logic [2:0] {
        brNone, brEq, brNe, brLt, brGe, brLtu, brGeu
    } brCondT;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   useImm;   // Operand B from immediate
        aluOpT  aluOp;
        brCondT brCond;
        logic   jump;     // JAL
        logic   jumpReg;  // JALR
    } ctrlT;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } fetchT;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        ctrlT                  ctrl;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   rs1Val;
        logic [`RV_XLEN-1:0]   rs2Val;
        logic [`RV_XLEN-1:0]   imm;
    } decT;

    typedef struct packed {
        logic                  valid;
        ctrlT                  ctrl;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   result;   // ALU value, address or link
        logic [`RV_XLEN-1:0]   storeData;
        logic [`RV_XLEN-1:0]   nextPc;
    } exT;

    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } wbT;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`RV_XLEN-1:0] adr;
        logic [`RV_XLEN-1:0] dat;
        logic [3:0]          sel;
    } wbReqT;

    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wbRspT;

endpackage

/* rvFetch.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvFetch import rvPkg::*; (
    input  logic                rstn,
    input  logic                reset,
    input  logic                retire,
    input  logic [`RV_XLEN-1:0] nextPc,
    output wbReqT               iReq,
    input  wbRspT               iRsp,
    output fetchT               fetchOut
);

    typedef enum logic [1:0] {
        sLaunch,  // One idle cycle out of reset
        sBus,
        sWait     // Instruction in flight
    } fetchStateT;

    fetchStateT          state;
    logic [`RV_XLEN-1:0] pc;
    logic                ackSeen;

    assign ackSeen = (state == sBus) && iRsp.ack;

    always_ff @(posedge rstn) begin
        if (reset) begin
            state <= sLaunch;
            pc <= `RV_RESET_PC;
            fetchOut.valid <= 1'b0;
        end else begin
            fetchOut.valid <= ackSeen;
            if (ackSeen) begin
                fetchOut.pc <= pc;
                fetchOut.instr <= iRsp.dat;
            end
            case (state)
                sLaunch: begin
                    state <= sBus;
                end
                sBus: begin
                    if (iRsp.ack) begin
                        state <= sWait;
                    end
                end
                sWait: begin
                    if (retire) begin
                        state <= sBus;
                        pc <= nextPc;
                    end
                end
                default: begin
                    state <= sLaunch;
                end
            endcase
        end
    end

    always_comb begin
        iReq = '0;
        iReq.cyc = (state == sBus);
        iReq.stb = (state == sBus);
        iReq.adr = pc;
        iReq.sel = 4'hF;  // Word reads only
    end

endmodule

/* rvDecode.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvDecode import rvPkg::*; (
    input  logic                  rstn,
    input  logic                  reset,
    input  fetchT                 fetchIn,
    output logic [`RV_REG_AW-1:0] rs1Addr,
    output logic [`RV_REG_AW-1:0] rs2Addr,
    input  logic [`RV_XLEN-1:0]   rs1Val,
    input  logic [`RV_XLEN-1:0]   rs2Val,
    output decT                   decOut
);

    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpBranch = 7'b1100011;

    logic [`RV_XLEN-1:0] instr;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                altF7;
    logic                shiftOk;
    ctrlT                ctrl;
    logic [`RV_XLEN-1:0] imm;

    function automatic aluOpT aluFromF3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign instr = fetchIn.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign altF7 = (funct7 == 7'b0100000);
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    // Shift immediates only allow funct7 of zero, SRAI also the alternate
    assign shiftOk = (funct7 == 7'b0) || (altF7 && funct3 == 3'b101);

    always_comb begin
        ctrl = '0;  // Anything unmatched retires as a no-op
        imm = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            OpReg: begin
                ctrl.regWrite = (funct7 == 7'b0) ||
                                (altF7 && (funct3 == 3'b000 || funct3 == 3'b101));
                ctrl.aluOp = aluFromF3(funct3, altF7);
            end
            OpImm: begin
                ctrl.regWrite = (funct3 != 3'b001 && funct3 != 3'b101) || shiftOk;
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluFromF3(funct3, altF7 && funct3 == 3'b101);
            end
            OpLoad: begin
                ctrl.regWrite = (funct3 == 3'b010);
                ctrl.memRead = (funct3 == 3'b010);
                ctrl.useImm = 1'b1;
            end
            OpStore: begin
                ctrl.memWrite = (funct3 == 3'b010);
                ctrl.useImm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OpJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OpJalr: begin
                ctrl.regWrite = (funct3 == 3'b000);
                ctrl.jumpReg = (funct3 == 3'b000);
                ctrl.useImm = 1'b1;
            end
            OpBranch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  ctrl.brCond = brEq;
                    3'b001:  ctrl.brCond = brNe;
                    3'b100:  ctrl.brCond = brLt;
                    3'b101:  ctrl.brCond = brGe;
                    3'b110:  ctrl.brCond = brLtu;
                    3'b111:  ctrl.brCond = brGeu;
                    default: ctrl.brCond = brNone;
                endcase
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_ff @(posedge rstn) begin
        if (reset) begin
            decOut.valid <= 1'b0;
        end else begin
            decOut.valid <= fetchIn.valid;
            if (fetchIn.valid) begin
                decOut.pc <= fetchIn.pc;
                decOut.ctrl <= ctrl;
                decOut.rd <= instr[11:7];
                decOut.rs1Val <= rs1Val;
                decOut.rs2Val <= rs2Val;
                decOut.imm <= imm;
            end
        end
    end

endmodule

/* rvRegFile.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvRegFile import rvPkg::*; (
    input  logic                  rstn,
    input  logic                  reset,
    input  logic [`RV_REG_AW-1:0] rs1Addr,
    input  logic [`RV_REG_AW-1:0] rs2Addr,
    output logic [`RV_XLEN-1:0]   rs1Val,
    output logic [`RV_XLEN-1:0]   rs2Val,
    input  wbT                    wbIn
);

    localparam int NumRegs = 2 ** `RV_REG_AW;

    logic [`RV_XLEN-1:0] regs [1:NumRegs-1];  // No storage for x0

    always_ff @(posedge rstn) begin
        if (reset) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbIn.valid && wbIn.rd != '0) begin
            regs[wbIn.rd] <= wbIn.data;
        end
    end

    assign rs1Val = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Val = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

/* rvExecute.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvExecute import rvPkg::*; (
    input  logic rstn,
    input  logic reset,
    input  decT  decIn,
    output exT   exOut
);

    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] aluRes;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic [`RV_XLEN-1:0] target;
    logic                brTaken;

    assign opA = decIn.rs1Val;
    assign opB = decIn.ctrl.useImm ? decIn.imm : decIn.rs2Val;
    assign shamt = opB[4:0];
    assign pcPlus4 = decIn.pc + `RV_XLEN'd4;

    always_comb begin
        case (decIn.ctrl.aluOp)
            aluSub:  aluRes = opA - opB;
            aluAnd:  aluRes = opA & opB;
            aluOr:   aluRes = opA | opB;
            aluXor:  aluRes = opA ^ opB;
            aluSlt:  aluRes = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu: aluRes = {{(`RV_XLEN-1){1'b0}}, opA < opB};
            aluSll:  aluRes = opA << shamt;
            aluSrl:  aluRes = opA >> shamt;
            aluSra:  aluRes = $signed(opA) >>> shamt;
            default: aluRes = opA + opB;
        endcase
    end

    // Branches always compare the two registers
    always_comb begin
        case (decIn.ctrl.brCond)
            brEq:    brTaken = (decIn.rs1Val == decIn.rs2Val);
            brNe:    brTaken = (decIn.rs1Val != decIn.rs2Val);
            brLt:    brTaken = $signed(decIn.rs1Val) < $signed(decIn.rs2Val);
            brGe:    brTaken = $signed(decIn.rs1Val) >= $signed(decIn.rs2Val);
            brLtu:   brTaken = decIn.rs1Val < decIn.rs2Val;
            brGeu:   brTaken = decIn.rs1Val >= decIn.rs2Val;
            default: brTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (decIn.ctrl.jumpReg) begin
            target = {aluRes[`RV_XLEN-1:1], 1'b0};  // rs1 + imm from the ALU
        end else if (decIn.ctrl.jump || brTaken) begin
            target = decIn.pc + decIn.imm;
        end else begin
            target = pcPlus4;
        end
    end

    always_ff @(posedge rstn) begin
        if (reset) begin
            exOut.valid <= 1'b0;
        end else begin
            exOut.valid <= decIn.valid;
            if (decIn.valid) begin
                exOut.ctrl <= decIn.ctrl;
                exOut.rd <= decIn.rd;
                exOut.result <= (decIn.ctrl.jump || decIn.ctrl.jumpReg) ? pcPlus4 : aluRes;
                exOut.storeData <= decIn.rs2Val;
                exOut.nextPc <= target;
            end
        end
    end

endmodule

/* rvMemWb.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvMemWb import rvPkg::*; (
    input  logic                rstn,
    input  logic                reset,
    input  exT                  exIn,
    output wbReqT               dReq,
    input  wbRspT               dRsp,
    output wbT                  wbOut,
    output logic                retire,
    output logic [`RV_XLEN-1:0] nextPc
);

    typedef enum logic {
        sIdle,
        sBus
    } memStateT;

    memStateT            state;
    logic [`RV_XLEN-1:0] adrQ;
    logic [`RV_XLEN-1:0] datQ;
    logic                weQ;
    logic                wrQ;  // Held regWrite of the load

    always_ff @(posedge rstn) begin
        if (reset) begin
            state <= sIdle;
            retire <= 1'b0;
            wbOut.valid <= 1'b0;
        end else begin
            retire <= 1'b0;
            wbOut.valid <= 1'b0;
            case (state)
                sIdle: begin
                    if (exIn.valid) begin
                        nextPc <= exIn.nextPc;
                        wbOut.rd <= exIn.rd;
                        adrQ <= exIn.result;
                        datQ <= exIn.storeData;
                        weQ <= exIn.ctrl.memWrite;
                        wrQ <= exIn.ctrl.regWrite;
                        if (exIn.ctrl.memRead || exIn.ctrl.memWrite) begin
                            state <= sBus;
                        end else begin
                            retire <= 1'b1;
                            wbOut.valid <= exIn.ctrl.regWrite;
                            wbOut.data <= exIn.result;
                        end
                    end
                end
                default: begin
                    if (dRsp.ack) begin
                        state <= sIdle;
                        retire <= 1'b1;
                        wbOut.valid <= wrQ;  // Never set for SW
                        wbOut.data <= dRsp.dat;
                    end
                end
            endcase
        end
    end

    always_comb begin
        dReq.cyc = (state == sBus);
        dReq.stb = (state == sBus);
        dReq.we = weQ;
        dReq.adr = adrQ;
        dReq.dat = datQ;
        dReq.sel = 4'hF;
    end

endmodule

/* rvCore.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvCore import rvPkg::*; (
    input  logic  rstn,
    input  logic  reset,
    output wbReqT iReq,
    input  wbRspT iRsp,
    output wbReqT dReq,
    input  wbRspT dRsp
);

    fetchT                 fetchS;
    decT                   decS;
    exT                    exS;
    wbT                    wbS;
    logic                  retire;
    logic [`RV_XLEN-1:0]   nextPc;  // Fed back from writeback
    logic [`RV_REG_AW-1:0] rs1Addr;
    logic [`RV_REG_AW-1:0] rs2Addr;
    logic [`RV_XLEN-1:0]   rs1Val;
    logic [`RV_XLEN-1:0]   rs2Val;

    rvFetch fetch0 (
        .rstn(rstn), .reset(reset), .retire(retire), .nextPc(nextPc),
        .iReq(iReq), .iRsp(iRsp), .fetchOut(fetchS)
    );

    rvDecode decode0 (
        .rstn(rstn), .reset(reset), .fetchIn(fetchS),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .decOut(decS)
    );

    rvRegFile regFile0 (
        .rstn(rstn), .reset(reset), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .wbIn(wbS)
    );

    rvExecute execute0 (
        .rstn(rstn), .reset(reset), .decIn(decS), .exOut(exS)
    );

    rvMemWb memWb0 (
        .rstn(rstn), .reset(reset), .exIn(exS), .dReq(dReq), .dRsp(dRsp),
        .wbOut(wbS), .retire(retire), .nextPc(nextPc)
    );

endmodule

/* rvCore_chk.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvCore_chk import rvPkg::*; (
    input logic  rstn,
    input logic  reset,
    input wbReqT iReq,
    input wbRspT iRsp,
    input wbReqT dReq,
    input wbRspT dRsp
);

    int failCount = 0;  // Read by the testbench at the end

    quietInReset: assert property (@(posedge rstn)
        $past(reset) |-> !iReq.cyc && !iReq.stb && !dReq.cyc && !dReq.stb)
    else begin
        $error("bus request active while reset was applied");
        failCount++;
    end

    firstFetch: assert property (@(posedge rstn)
        $fell(reset) |=> iReq.cyc && iReq.stb && iReq.adr == `RV_RESET_PC)
    else begin
        $error("first fetch after reset not at the reset PC");
        failCount++;
    end

    iHold: assert property (@(posedge rstn) disable iff (reset)
        iReq.stb && !iRsp.ack |=> iReq.cyc && iReq.stb && $stable(iReq.adr)
            && $stable(iReq.we) && $stable(iReq.dat))
    else begin
        $error("instruction request changed before its ack");
        failCount++;
    end

    dHold: assert property (@(posedge rstn) disable iff (reset)
        dReq.stb && !dRsp.ack |=> dReq.cyc && dReq.stb && $stable(dReq.adr)
            && $stable(dReq.we) && $stable(dReq.dat))
    else begin
        $error("data request changed before its ack");
        failCount++;
    end

    iAckInCycle: assert property (@(posedge rstn) disable iff (reset)
        iRsp.ack |-> iReq.cyc && iReq.stb)
    else begin
        $error("instruction ack outside a bus cycle");
        failCount++;
    end

    dAckInCycle: assert property (@(posedge rstn) disable iff (reset)
        dRsp.ack |-> dReq.cyc && dReq.stb)
    else begin
        $error("data ack outside a bus cycle");
        failCount++;
    end

endmodule

bind rvCore rvCore_chk chk0 (.*);

/* rvCore_tb.sv */
`timescale 1ns/1ps
`include "rvCore_params.svh"

module rvCore_tb import rvPkg::*; ();

    localparam logic [31:0] OperandBase = 32'h0000_0200;
    localparam logic [31:0] SigBase = 32'h0000_0300;

    logic        rstn = 1'b0;
    logic        reset;
    wbReqT       iReq;
    wbRspT       iRsp;
    wbReqT       dReq;
    wbRspT       dRsp;
    logic [31:0] mem [0:255];
    logic [31:0] expSig [0:63];
    int          testOf [0:63];
    logic        sigSeen [0:63];
    logic [31:0] expNext [logic [31:0]];  // Fetch that must follow a given pc
    int          testLast [0:3];
    string       testName [0:3] = '{"register ALU", "immediate ALU and x0",
                                    "branches and jumps", "unknown encoding"};
    logic [15:0] lfsr = 16'd38;
    logic [31:0] pc = `RV_RESET_PC;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] lastPc = 32'hFFFF_FFFF;
    int          nInstr = 0;
    int          nSig = 0;
    int          nStored = 0;
    int          curTest = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;
    int          iCnt = -1;
    int          dCnt = -1;

    rvCore dut0 (
        .rstn(rstn), .reset(reset), .iReq(iReq), .iRsp(iRsp), .dReq(dReq), .dRsp(dRsp)
    );

    always #20 rstn = ~rstn;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic lessSigned(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, lessSigned(a, b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> b[4:0]) |
                            ((alt && a[31]) ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic refBranch(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return lessSigned(a, b);
            3'd5:    return !lessSigned(a, b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] rType(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[pc[9:2]] = w;
        pc = pc + 32'd4;
        nInstr++;
    endtask

    // SW rs, sig(x0) and record what it must store
    task automatic storeSig(input logic [4:0] rs, input logic [31:0] value);
        logic [31:0] a;
        a = SigBase + 32'(4 * nSig);
        emit({a[11:5], rs, 5'd0, 3'b010, a[4:0], 7'h23});
        expSig[nSig] = value;
        testOf[nSig] = curTest;
        testLast[curTest] = nSig;
        nSig++;
    endtask

    task automatic buildProgram();
        logic [3:0]  regOps [0:9];
        logic [14:0] immOps [0:8];
        logic [2:0]  brOps [0:5];
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [31:0] at;
        logic        taken;
        regOps = '{4'h0, 4'h8, 4'h7, 4'h6, 4'h4, 4'h2, 4'h3, 4'h1, 4'h5, 4'hD};
        immOps = '{{3'd0, 12'hED4}, {3'd7, 12'h5A5}, {3'd6, 12'hF00}, {3'd4, 12'h3C3},
                   {3'd2, 12'hFFB}, {3'd3, 12'h123}, {3'd1, 12'h007}, {3'd5, 12'h00D},
                   {3'd5, 12'h413}};
        brOps = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        curTest = 0;
        emit(iType(7'h03, 3'b010, 5'd1, 5'd0, OperandBase[11:0]));
        emit(iType(7'h03, 3'b010, 5'd2, 5'd0, OperandBase[11:0] + 12'd4));
        for (int k = 0; k < 10; k++) begin
            emit(rType(regOps[k][2:0], regOps[k][3], 5'd3, 5'd1, 5'd2));
            storeSig(5'd3, refAlu(regOps[k][2:0], regOps[k][3], opA, opB));
        end
        curTest = 1;
        for (int k = 0; k < 9; k++) begin
            f3 = immOps[k][14:12];
            imm = immOps[k][11:0];
            emit(iType(7'h13, f3, 5'd3, 5'd1, imm));
            storeSig(5'd3, refAlu(f3, f3 == 3'd5 && imm[10], opA, {{20{imm[11]}}, imm}));
        end
        emit(iType(7'h13, 3'd0, 5'd0, 5'd1, 12'd1));  // Write to x0 is dropped
        storeSig(5'd0, 32'h0);
        curTest = 2;
        for (int k = 0; k < 12; k++) begin
            f3 = brOps[k / 2];
            r1 = (f3[2] && k % 2 == 1) ? 5'd2 : 5'd1;
            r2 = (f3[2] == (k % 2 == 1)) ? 5'd1 : 5'd2;
            taken = refBranch(f3, (r1 == 5'd1) ? opA : opB, (r2 == 5'd1) ? opA : opB);
            emit(iType(7'h13, 3'd0, 5'd4, 5'd0, 12'd1));
            at = pc;
            emit(bType(f3, r1, r2, 13'd8));
            emit(iType(7'h13, 3'd0, 5'd4, 5'd0, 12'd0));  // Skipped when taken
            storeSig(5'd4, {31'b0, taken});
            expNext[at] = taken ? at + 32'd8 : at + 32'd4;
        end
        at = pc;
        emit(jType(5'd5, 21'd8));
        emit(iType(7'h13, 3'd0, 5'd5, 5'd0, 12'd0));
        storeSig(5'd5, at + 32'd4);
        expNext[at] = at + 32'd8;
        at = pc;
        emit(iType(7'h67, 3'd0, 5'd7, 5'd0, at[11:0] + 12'd9));  // Odd target, bit 0 dropped
        emit(iType(7'h13, 3'd0, 5'd7, 5'd0, 12'd0));
        storeSig(5'd7, at + 32'd4);
        expNext[at] = at + 32'd8;
        curTest = 3;
        at = pc;
        emit(32'h0);
        expNext[at] = at + 32'd4;
        emit(iType(7'h13, 3'd0, 5'd8, 5'd0, 12'h05A));
        storeSig(5'd8, 32'h5A);
        emit(jType(5'd0, 21'd0));  // Park here
    endtask

    task automatic checkStore(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] off;
        int          idx;
        off = adr - SigBase;
        idx = int'(off[31:2]);
        mem[adr[9:2]] = dat;
        if (adr < SigBase || idx >= nSig) begin
            $display("Store to %h falls outside the signature area", adr);
            errors++;
        end else if (sigSeen[idx]) begin
            $display("Signature word %0d was stored a second time", idx);
            errors++;
        end else begin
            sigSeen[idx] = 1'b1;
            checks++;
            assert (dat == expSig[idx]) else begin
                $display("MISMATCH dReq.dat at %h: expected %h, got %h", adr, expSig[idx], dat);
                errors++;
            end
            nStored++;
            if (idx == testLast[testOf[idx]]) begin
                $display("%s done, %0d error(s) so far", testName[testOf[idx]], errors);
            end
        end
    endtask

    always @(posedge rstn) begin
        #1;
        if (reset || iRsp.ack) begin
            iRsp.ack = 1'b0;
            iCnt = -1;
        end else if (iReq.stb) begin
            if (iCnt < 0) begin  // New fetch
                if (expNext.exists(lastPc)) begin
                    checks++;
                    assert (iReq.adr == expNext[lastPc]) else begin
                        $display("MISMATCH iReq.adr after pc %h: expected %h, got %h",
                                 lastPc, expNext[lastPc], iReq.adr);
                        errors++;
                    end
                end
                lastPc = iReq.adr;
                iCnt = int'(randBits(2));
            end
            if (iCnt == 0) begin
                iRsp.ack = 1'b1;
                iRsp.dat = mem[iReq.adr[9:2]];
                iCnt = -1;
            end else begin
                iCnt--;
            end
        end
    end

    always @(posedge rstn) begin
        #1;
        if (reset || dRsp.ack) begin
            dRsp.ack = 1'b0;
            dCnt = -1;
        end else if (dReq.stb) begin
            if (dCnt < 0) begin
                dCnt = int'(randBits(2));
            end
            if (dCnt == 0) begin
                dRsp.ack = 1'b1;
                dRsp.dat = mem[dReq.adr[9:2]];
                if (dReq.we) begin
                    checkStore(dReq.adr, dReq.dat);
                end
                dCnt = -1;
            end else begin
                dCnt--;
            end
        end
    end

    always @(posedge rstn) begin
        cycles++;
        if (cycles == limit) begin
            $display("Timeout: the program did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        iRsp = '0;
        dRsp = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            sigSeen[i] = 1'b0;
        end
        opA = randBits(32);
        opB = randBits(32);
        if (opA == opB) begin
            opB = ~opA;  // Branch pairs need distinct operands
        end
        mem[OperandBase[9:2]] = opA;
        mem[OperandBase[9:2] + 1] = opB;
        buildProgram();
        limit = (nInstr + nSig) * 10 * 2;
        repeat (10) @(posedge rstn);
        #1 reset = 1'b0;
        wait (nStored == nSig);
        repeat (4) @(posedge rstn);
        errors = errors + dut0.chk0.failCount;
        $display("tests 4, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
rvPkg.sv
rvFetch.sv
rvDecode.sv
rvRegFile.sv
rvExecute.sv
rvMemWb.sv
rvCore.sv
rvCore_chk.sv
rvCore_tb.sv

/* Bender.yml */
package:
  name: rvcore

sources:
  - include_dirs:
      - .
    files:
      - rvPkg.sv
      - rvFetch.sv
      - rvDecode.sv
      - rvRegFile.sv
      - rvExecute.sv
      - rvMemWb.sv
      - rvCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - rvCore_chk.sv
      - rvCore_tb.sv
